// ==== common/histPkg.sv ====
package histPkg;

    // bin address width, 2**6 = 64 bins
    localparam int NB_DEFAULT = 6;

    // event data word width, low NB bits pick the bin
    localparam int NP_DEFAULT = 12;

    // bin count width, counts saturate at all ones
    localparam int COUNT_W_DEFAULT = 16;

    // programmed event count and event counter width
    localparam int ACQ_W = 24;

    // acquisition phases
    // the drain phase covers the final read-modify-write of the last event
    // before the readout reads the RAM
    typedef enum logic [2:0] {
        phIdle    = 3'd0,   // waiting for start
        phClear   = 3'd1,   // zero every bin
        phAccum   = 3'd2,   // count events
        phDrain   = 3'd3,   // let the pipeline empty
        phReadout = 3'd4    // stream the bins out
    } histPhaseT;

endpackage

// ==== common/histRamIf.sv ====
interface histRamIf #(
    parameter int NB      = histPkg::NB_DEFAULT,
    parameter int COUNT_W = histPkg::COUNT_W_DEFAULT
) ();

    logic [NB-1:0]      waddr;     // write port
    logic               wEnable;
    logic [COUNT_W-1:0] wdata;
    logic [NB-1:0]      raddr;     // read port
    logic               rEnable;
    logic [COUNT_W-1:0] rdata;     // valid one cycle after rEnable

    modport ctrl (
        output waddr,
        output wEnable,
        output wdata,
        output raddr,
        output rEnable,
        input  rdata
    );

    modport mem (
        input  waddr,
        input  wEnable,
        input  wdata,
        input  raddr,
        input  rEnable,
        output rdata
    );

endinterface

// ==== histCore/histRam.sv ====
module histRam #(
    parameter int NB      = histPkg::NB_DEFAULT,
    parameter int COUNT_W = histPkg::COUNT_W_DEFAULT
) (
    input  logic clk,
    histRamIf.mem ram
);

    localparam int DEPTH = 2 ** NB;

    logic [COUNT_W-1:0] mem [DEPTH];

    // port a, synchronous write
    always_ff @(posedge clk) begin
        if (ram.wEnable) begin
            mem[ram.waddr] <= ram.wdata;
        end
    end

    // port b, registered read
    // a same-cycle write to the same address is not seen, old data comes back
    always_ff @(posedge clk) begin
        if (ram.rEnable) begin
            ram.rdata <= mem[ram.raddr];
        end
    end

endmodule

// ==== histCore/histFsm.sv ====
module histFsm #(
    parameter int NB      = histPkg::NB_DEFAULT,
    parameter int NP      = histPkg::NP_DEFAULT,
    parameter int COUNT_W = histPkg::COUNT_W_DEFAULT
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      startPulse,
    input  logic [histPkg::ACQ_W-1:0] acqLength,
    input  logic                      dataValid,
    input  logic [NP-1:0]             data,
    histRamIf.ctrl                    ram,
    output logic                      phaseDone,
    output logic                      binValid,
    output logic [NB-1:0]             binAddr,
    output logic [COUNT_W-1:0]        binCount
);

    histPkg::histPhaseT phase;
    histPkg::histPhaseT phaseNext;

    logic [NB-1:0]             binCnt;       // clear and readout address
    logic                      lastBin;
    logic [histPkg::ACQ_W-1:0] evCount;      // accepted events
    logic [histPkg::ACQ_W-1:0] evCountInc;
    logic                      accept;
    logic                      lastEvent;
    logic                      drainCnt;

    // stage 1: read issued last cycle, rdata valid now
    logic                      s1Valid;
    logic [NB-1:0]             s1Addr;
    // stage 2: incremented count, written this cycle
    logic                      s2Valid;
    logic [NB-1:0]             s2Addr;
    logic [COUNT_W-1:0]        s2Data;
    // stage 3: count written last cycle, missed by the read in that cycle
    logic                      s3Valid;
    logic [NB-1:0]             s3Addr;
    logic [COUNT_W-1:0]        s3Data;

    logic [COUNT_W-1:0]        baseCount;
    logic [COUNT_W-1:0]        incCount;

    assign lastBin    = (binCnt == {NB{1'b1}});
    assign evCountInc = evCount + 1'b1;
    assign accept     = (phase == histPkg::phAccum) && dataValid && (evCount != acqLength);
    assign lastEvent  = accept && (evCountInc == acqLength);

    // forwarding, the newest pending write wins
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCount = s2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Data;
        end else begin
            baseCount = ram.rdata;
        end
    end

    // hold at all ones
    assign incCount = (&baseCount) ? baseCount : baseCount + 1'b1;

    always_comb begin
        phaseNext = phase;
        case (phase)
            histPkg::phIdle:
                if (startPulse) phaseNext = histPkg::phClear;
            histPkg::phClear:
                if (lastBin) begin
                    // nothing to count, go straight to readout
                    phaseNext = (acqLength == '0) ? histPkg::phReadout : histPkg::phAccum;
                end
            histPkg::phAccum:
                if (lastEvent) phaseNext = histPkg::phDrain;
            histPkg::phDrain:
                if (drainCnt) phaseNext = histPkg::phReadout;
            histPkg::phReadout:
                if (lastBin) phaseNext = histPkg::phIdle;
            default:
                phaseNext = histPkg::phIdle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase     <= histPkg::phIdle;
            binCnt    <= '0;
            evCount   <= '0;
            drainCnt  <= 1'b0;
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
            s3Valid   <= 1'b0;
            binValid  <= 1'b0;
            phaseDone <= 1'b0;
        end else begin
            phase <= phaseNext;

            // wraps back to 0 after the last bin
            if (phase == histPkg::phClear || phase == histPkg::phReadout) begin
                binCnt <= binCnt + 1'b1;
            end else begin
                binCnt <= '0;
            end

            if (phase == histPkg::phIdle) begin
                evCount <= '0;
            end else if (accept) begin
                evCount <= evCountInc;
            end

            drainCnt <= (phase == histPkg::phDrain) ? ~drainCnt : 1'b0;

            s1Valid <= accept;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;

            binValid  <= (phase == histPkg::phReadout);
            phaseDone <= (phase == histPkg::phReadout) && lastBin;    // with the last bin
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1Addr  <= data[NB-1:0];
        s2Addr  <= s1Addr;
        s2Data  <= incCount;
        s3Addr  <= s2Addr;
        s3Data  <= s2Data;
        binAddr <= binCnt;
    end

    // write port: zeros during clear, counts from stage 2 otherwise
    assign ram.wEnable = (phase == histPkg::phClear) || s2Valid;
    assign ram.waddr   = (phase == histPkg::phClear) ? binCnt : s2Addr;
    assign ram.wdata   = (phase == histPkg::phClear) ? '0 : s2Data;

    // read port: event bin while counting, bin counter during readout
    assign ram.rEnable = (phase == histPkg::phReadout) || accept;
    assign ram.raddr   = (phase == histPkg::phReadout) ? binCnt : data[NB-1:0];

    assign binCount = ram.rdata;    // registered in the RAM, lines up with binValid

endmodule

// ==== verilog/histConfig.sv ====
module histConfig (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      cfgWe,
    input  logic [histPkg::ACQ_W-1:0] cfgData,
    input  logic                      start,
    input  logic                      phaseDone,
    output logic [histPkg::ACQ_W-1:0] acqLength,
    output logic                      startPulse,
    output logic                      busy,
    output logic                      done
);

    // start only goes through while no run is active
    assign startPulse = start && !busy;

    // event count, frozen for the whole run
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqLength <= '0;
        end else if (cfgWe && !busy) begin
            acqLength <= cfgData;
        end
    end

    // status flags
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (startPulse) begin
            busy <= 1'b1;
            done <= 1'b0;    // done holds until the next start
        end else if (phaseDone) begin
            busy <= 1'b0;    // last bin went out last cycle
            done <= 1'b1;
        end
    end

endmodule

// ==== verilog/histTop.sv ====
module histTop #(
    parameter int NB      = histPkg::NB_DEFAULT,
    parameter int NP      = histPkg::NP_DEFAULT,
    parameter int COUNT_W = histPkg::COUNT_W_DEFAULT
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      cfgWe,
    input  logic [histPkg::ACQ_W-1:0] cfgData,
    input  logic                      start,
    input  logic                      dataValid,
    input  logic [NP-1:0]             data,
    output logic                      busy,
    output logic                      done,
    output logic                      binValid,
    output logic [NB-1:0]             binAddr,
    output logic [COUNT_W-1:0]        binCount
);

    logic [histPkg::ACQ_W-1:0] acqLength;
    logic                      startPulse;
    logic                      phaseDone;    // end of readout

    histRamIf #(
        .NB      (NB),
        .COUNT_W (COUNT_W)
    ) ramBus ();

    histConfig i_config (
        .clk        (clk),
        .res        (res),
        .cfgWe      (cfgWe),
        .cfgData    (cfgData),
        .start      (start),
        .phaseDone  (phaseDone),
        .acqLength  (acqLength),
        .startPulse (startPulse),
        .busy       (busy),
        .done       (done)
    );

    histFsm #(
        .NB      (NB),
        .NP      (NP),
        .COUNT_W (COUNT_W)
    ) i_fsm (
        .clk        (clk),
        .res        (res),
        .startPulse (startPulse),
        .acqLength  (acqLength),
        .dataValid  (dataValid),
        .data       (data),
        .ram        (ramBus.ctrl),
        .phaseDone  (phaseDone),
        .binValid   (binValid),
        .binAddr    (binAddr),
        .binCount   (binCount)
    );

    histRam #(
        .NB      (NB),
        .COUNT_W (COUNT_W)
    ) i_ram (
        .clk (clk),
        .ram (ramBus.mem)
    );

endmodule

// ==== dv/histClkGen.sv ====
module histClkGen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic res
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        res = 1'b0;                     // asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        #1 res = 1'b1;                  // released just after an edge
    end

endmodule

// ==== dv/histTb.sv ====
module histTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB      = histPkg::NB_DEFAULT;
    localparam int NP      = histPkg::NP_DEFAULT;
    localparam int COUNT_W = histPkg::COUNT_W_DEFAULT;
    localparam int ACQ_W   = histPkg::ACQ_W;
    localparam int BINS    = 2 ** NB;
    localparam logic [COUNT_W-1:0] MAX_COUNT = '1;

    localparam int RANDOM_CYCLES = 600;
    localparam int RANDOM_LENGTH = 300;
    localparam int FWD_CYCLES    = 120;     // upper bound of the forwarding pattern
    localparam int SAT_EVENTS    = 2 ** COUNT_W + 200;
    localparam int RERUN_CYCLES  = 150;
    localparam int RUNS          = 6;
    localparam int RUN_CYCLES    = 3 * BINS + 40;    // clear, drain, readout and slack
    localparam int TOTAL_CYCLES  = RUNS * RUN_CYCLES + RANDOM_CYCLES + FWD_CYCLES
                                   + SAT_EVENTS + 2 * RERUN_CYCLES;
    localparam int WATCHDOG_NS   = TOTAL_CYCLES * 10 * 3 / 2;

    logic               clk;
    logic               res;
    logic               cfgWe;
    logic [ACQ_W-1:0]   cfgData;
    logic               start;
    logic               dataValid;
    logic [NP-1:0]      data;
    logic               busy;
    logic               done;
    logic               binValid;
    logic [NB-1:0]      binAddr;
    logic [COUNT_W-1:0] binCount;

    int errors   = 0;
    int runs     = 0;
    int cycle    = 0;
    int doneRise = -1;                      // first cycle of done in this run
    int seed;
    bit disturb;                            // poke cfgWe and start mid-run

    logic [COUNT_W-1:0] refHist [BINS];     // reference histogram
    bit                 evValid [$];        // one entry per accumulate cycle
    logic [NP-1:0]      evData [$];
    logic [NB-1:0]      gotAddr [$];        // collected readout stream
    logic [COUNT_W-1:0] gotCount [$];
    int                 gotCycle [$];

    histClkGen i_clkGen (
        .clk (clk),
        .res (res)
    );

    histTop i_dut (
        .clk       (clk),
        .res       (res),
        .cfgWe     (cfgWe),
        .cfgData   (cfgData),
        .start     (start),
        .dataValid (dataValid),
        .data      (data),
        .busy      (busy),
        .done      (done),
        .binValid  (binValid),
        .binAddr   (binAddr),
        .binCount  (binCount)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // readout stream and done rise sampled mid-cycle
    always @(negedge clk) begin
        if (binValid === 1'b1) begin
            gotAddr.push_back(binAddr);
            gotCount.push_back(binCount);
            gotCycle.push_back(cycle);
        end
        if (done === 1'b1 && doneRise < 0) begin
            doneRise = cycle;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic addEvent(input bit valid, input logic [NB-1:0] bin);
        logic [NP-1:0] word;
        word = $random(seed);               // random upper bits
        word[NB-1:0] = bin;
        evValid.push_back(valid);
        evData.push_back(word);
    endtask

    function automatic int countValid();
        int n;
        n = 0;
        foreach (evValid[i]) n += evValid[i];
        return n;
    endfunction

    task automatic startRun(input logic [ACQ_W-1:0] length);
        cfgWe   = 1'b1;
        cfgData = length;
        nextCycle();
        cfgWe = 1'b0;
        start = 1'b1;
        gotAddr.delete();
        gotCount.delete();
        gotCycle.delete();
        nextCycle();
        start = 1'b0;
        doneRise = -1;
        assert (busy === 1'b1) else begin
            errors++;
            $display("[ERROR] busy exp 0x1 got 0x%h one cycle after start", busy);
        end
    endtask

    task automatic runEvents(input logic [ACQ_W-1:0] length);
        int accepted;
        logic [NB-1:0] bin;
        accepted = 0;
        foreach (refHist[b]) refHist[b] = '0;
        // events in the last clear cycles must be dropped
        for (int k = 0; k < BINS; k++) begin
            dataValid = (k >= BINS - 4);
            data      = $random(seed);
            nextCycle();
        end
        foreach (evValid[i]) begin
            dataValid = evValid[i];
            data      = evData[i];
            if (disturb && i == 0) begin
                cfgWe   = 1'b1;
                cfgData = length + 7;
                start   = 1'b1;
            end
            if (evValid[i] && accepted < length) begin
                accepted++;
                bin = evData[i][NB-1:0];
                if (refHist[bin] != MAX_COUNT) refHist[bin]++;    // saturating
            end
            nextCycle();
            cfgWe = 1'b0;
            start = 1'b0;
        end
        dataValid = 1'b0;
    endtask

    task automatic finishRun(output int doneCycle);
        int n;
        n = 0;
        while (doneRise < 0 && n < RUN_CYCLES) begin
            @(negedge clk);
            #1;
            n++;
        end
        doneCycle = doneRise;
        assert (doneRise >= 0) else begin
            errors++;
            $display("done did not rise within %0d cycles after the events", RUN_CYCLES);
        end
        if (doneRise >= 0) begin
            assert (busy === 1'b0) else begin
                errors++;
                $display("[ERROR] busy exp 0x0 got 0x%h while done is high", busy);
            end
        end
        nextCycle();
    endtask

    task automatic runAndCheck(input string name, input logic [ACQ_W-1:0] length);
        int doneCycle;
        int last;
        runs++;
        startRun(length);
        runEvents(length);
        finishRun(doneCycle);
        assert (gotAddr.size() == BINS) else begin
            errors++;
            $display("%s: readout gave %0d bins, expected %0d", name, gotAddr.size(), BINS);
        end
        for (int i = 0; i < gotAddr.size() && i < BINS; i++) begin
            assert (gotAddr[i] == NB'(i)) else begin
                errors++;
                $display("[ERROR] %s binAddr exp 0x%h got 0x%h", name, NB'(i), gotAddr[i]);
            end
            assert (gotCount[i] === refHist[i]) else begin
                errors++;
                $display("[ERROR] %s binCount bin 0x%h exp 0x%h got 0x%h",
                         name, NB'(i), refHist[i], gotCount[i]);
            end
            assert (gotCycle[i] == gotCycle[0] + i) else begin
                errors++;
                $display("%s: readout stream has a gap before bin %0d", name, i);
            end
        end
        last = gotCycle.size() - 1;
        if (last >= 0 && doneCycle >= 0) begin
            assert (doneCycle == gotCycle[last] + 1) else begin
                errors++;
                $display("%s: done rose %0d cycles after the last bin",
                         name, doneCycle - gotCycle[last]);
            end
        end
        evValid.delete();
        evData.delete();
    endtask

    task automatic testZeroLength();
        assert (busy === 1'b0 && done === 1'b0 && binValid === 1'b0) else begin
            errors++;
            $display("[ERROR] after reset busy 0x%h done 0x%h binValid 0x%h, exp all 0x0",
                     busy, done, binValid);
        end
        runAndCheck("zero length", '0);
    endtask

    task automatic testRandomEvents();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            addEvent(($random(seed) & 3) != 0, $random(seed));    // about 3 in 4 cycles
        end
        runAndCheck("random events", RANDOM_LENGTH);
    endtask

    task automatic testForwarding();
        for (int i = 0; i < 10; i++) addEvent(1'b1, 3);    // back to back
        for (int i = 0; i < 6; i++) addEvent(1'b1, (i % 2) ? 9 : 7);
        addEvent(1'b1, 12);
        addEvent(1'b0, 0);
        addEvent(1'b1, 12);                                 // two cycles apart
        addEvent(1'b0, 0);
        addEvent(1'b1, 12);
        addEvent(1'b1, 20);
        addEvent(1'b1, 21);
        addEvent(1'b1, 20);
        addEvent(1'b1, 22);
        addEvent(1'b1, 22);
        addEvent(1'b1, 20);
        for (int i = 0; i < 40; i++) addEvent(1'b1, $unsigned($random(seed)) % 3);
        runAndCheck("forwarding", countValid());
    endtask

    task automatic testSaturation();
        for (int i = 0; i < SAT_EVENTS; i++) begin
            addEvent(1'b1, (i % 1000 == 500) ? 6 : 5);    // bin 5 runs past all ones
        end
        runAndCheck("saturation", SAT_EVENTS);
    endtask

    task automatic testRerun();
        for (int i = 0; i < RERUN_CYCLES; i++) addEvent(1'b1, $random(seed) & 8'h1f);
        runAndCheck("first run", 100);
        // upper half only, so leftover counts would show up in the lower half
        for (int i = 0; i < RERUN_CYCLES - 30; i++) begin
            addEvent(($random(seed) & 1) != 0, 32 + ($random(seed) & 8'h1f));
        end
        disturb = 1'b1;
        runAndCheck("second run", countValid() - 10);
        disturb = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        cfgWe     = 1'b0;
        cfgData   = '0;
        start     = 1'b0;
        dataValid = 1'b0;
        data      = '0;
        disturb   = 1'b0;
        seed      = 32'h1632695a;
        wait (res === 1'b1);
        nextCycle();
        testZeroLength();
        testRandomEvents();
        testForwarding();
        testSaturation();
        testRerun();
        $display("summary: %0d runs, %0d errors", runs, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/histPkg.sv
common/histRamIf.sv
histCore/histRam.sv
histCore/histFsm.sv
verilog/histConfig.sv
verilog/histTop.sv
dv/histClkGen.sv
dv/histTb.sv

// ==== Bender.yml ====
package:
  name: hist_builder

sources:
  # shared package and RAM interface
  - common/histPkg.sv
  - common/histRamIf.sv
  # histogram core
  - histCore/histRam.sv
  - histCore/histFsm.sv
  # configuration and top level
  - verilog/histConfig.sv
  - verilog/histTop.sv
  # testbench
  - target: simulation
    files:
      - dv/histClkGen.sv
      - dv/histTb.sv
